//--- source/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand width of Y and the bus
`define ALU_WIDTH 32

// Opcode field width
`define ALU_OP_BITS 4

// Radix-4 Booth retires two multiplier bits per step
`define ALU_MUL_STEPS 16

// Non-restoring divide produces one quotient bit per step
`define ALU_DIV_STEPS 32

// Shift amount taken from the low bits of the bus operand
`define ALU_SH_BITS 5

// Step counter width, wide enough for the divide count
`define ALU_CNT_BITS 6

`endif

//--- source/alu_pkg.sv
`include "alu_defs.svh"

package alu_pkg;

	// Opcode map, codes 13 to 15 unused
	typedef enum logic [`ALU_OP_BITS-1:0] {
		OP_AND    = 4'd0,
		OP_OR     = 4'd1,
		OP_NEGATE = 4'd2,
		OP_NOT    = 4'd3,
		OP_ADD    = 4'd4,
		OP_SUB    = 4'd5,
		OP_MUL    = 4'd6,
		OP_DIV    = 4'd7,
		OP_SHR    = 4'd8,
		OP_SHRA   = 4'd9,
		OP_SHL    = 4'd10,
		OP_ROR    = 4'd11,
		OP_ROL    = 4'd12
	} alu_op_e;

	// Controller states
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		ITER,
		DONE
	} ctrl_state_e;

endpackage

//--- source/iter_if.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

interface iter_if;

	// One-cycle start with operands
	logic                  load;
	logic [`ALU_WIDTH-1:0] a;
	logic [`ALU_WIDTH-1:0] b;

	// Advance by one iteration
	logic                  step;

	// Result halves from the unit
	logic [`ALU_WIDTH-1:0] hi;
	logic [`ALU_WIDTH-1:0] lo;

	// Controller side
	modport ctrl (output load, output a, output b, output step, input hi, input lo);

	// Data unit side
	modport unit (input load, input a, input b, input step, output hi, output lo);

endinterface

//--- source/alu_ctrl.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_ctrl
	import alu_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req,
	input  alu_op_e                 op,
	input  logic [`ALU_WIDTH-1:0]   y,
	input  logic [`ALU_WIDTH-1:0]   bus_in,
	output logic                    ack,
	output logic [2*`ALU_WIDTH-1:0] c,
	output logic                    cnt_start,
	output logic [5:0]              cnt_steps,
	input  logic                    cnt_last,
	iter_if.ctrl                    mul,
	iter_if.ctrl                    div,
	output logic [`ALU_WIDTH-1:0]   a_q,
	output logic [`ALU_WIDTH-1:0]   b_q,
	output alu_op_e                 op_q,
	input  logic [2*`ALU_WIDTH-1:0] simple_res
);

	ctrl_state_e state;
	// Divider owes one sign fix-up step after the counter ends
	logic        fix_q;
	logic        is_mul;
	logic        is_div;

	assign is_mul = (op_q == OP_MUL);
	assign is_div = (op_q == OP_DIV);

	// Counter launch in EXEC for the iterative ops only
	assign cnt_start = (state == EXEC) && (is_mul || is_div);
	assign cnt_steps = is_div ? 6'(`ALU_DIV_STEPS) : 6'(`ALU_MUL_STEPS);

	// Multiplier port
	assign mul.load = (state == EXEC) && is_mul;
	assign mul.a    = a_q;
	assign mul.b    = b_q;
	assign mul.step = (state == ITER) && is_mul;

	// Divider port
	assign div.load = (state == EXEC) && is_div;
	assign div.a    = a_q;
	assign div.b    = b_q;
	assign div.step = (state == ITER) && is_div;

	// Operands captured as the request is accepted
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			a_q <= y;
			b_q <= bus_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ack   <= 1'b0;
			c     <= '0;
			fix_q <= 1'b0;
			op_q  <= OP_AND;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						op_q  <= op;
						state <= EXEC;
					end
				end
				EXEC: begin
					// Single-cycle result goes straight into c
					if (is_mul || is_div) begin
						state <= ITER;
					end else begin
						c     <= simple_res;
						state <= DONE;
					end
				end
				ITER: begin
					if (fix_q) begin
						fix_q <= 1'b0;
						state <= DONE;
					end else if (cnt_last) begin
						if (is_div)
							fix_q <= 1'b1;
						else
							state <= DONE;
					end
				end
				DONE: begin
					// First DONE cycle raises ack with the unit result
					if (!ack) begin
						ack <= 1'b1;
						if (is_mul)
							c <= {mul.hi, mul.lo};
						else if (is_div)
							c <= {div.hi, div.lo};
					end else if (!req) begin
						ack   <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Ack only once a result is held
	a_no_early_ack: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE || state == EXEC) |-> !ack);

	// Units only advance while iterating
	a_step_in_iter: assert property (@(posedge clk) disable iff (rst)
		(mul.step || div.step) |-> (state == ITER));

	// Requester keeps req up through the iterations
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		(state == ITER) |-> req);

endmodule

//--- source/step_counter.sv
`timescale 1ns/1ps

module step_counter (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic [5:0] steps,
	output logic       busy,
	output logic       last
);

	// Steps still to run
	logic [5:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			count <= steps;
		end else if (busy) begin
			// One step per cycle
			count <= count - 6'd1;
		end
	end

	assign busy = (count != 6'd0);

	// Final step cycle
	assign last = (count == 6'd1);

	// A new launch only once the previous run has drained
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy);

endmodule

//--- source/single_cycle_unit.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module single_cycle_unit
	import alu_pkg::*;
(
	input  logic [`ALU_WIDTH-1:0]   a,
	input  logic [`ALU_WIDTH-1:0]   b,
	input  alu_op_e                 op,
	output logic [2*`ALU_WIDTH-1:0] res
);

	// Shift amount from the bus operand
	logic [`ALU_SH_BITS-1:0]  sh;
	// A side by side, so rotates become plain shifts
	logic [2*`ALU_WIDTH-1:0] dbl;
	logic [2*`ALU_WIDTH-1:0] rot_r;
	logic [2*`ALU_WIDTH-1:0] rot_l;
	logic [`ALU_WIDTH-1:0]   lo;

	assign sh  = b[`ALU_SH_BITS-1:0];
	assign dbl = {a, a};

	// Right rotate lands in the low word
	assign rot_r = dbl >> sh;

	// Left rotate lands in the high word
	assign rot_l = dbl << sh;

	always_comb begin
		case (op)
			// Bitwise logic
			OP_AND:    lo = a & b;
			OP_OR:     lo = a | b;
			// Two's complement of Y
			OP_NEGATE: lo = -a;
			OP_NOT:    lo = ~a;
			// Wraps at 32 bits
			OP_ADD:    lo = a + b;
			OP_SUB:    lo = a - b;
			// Zero fill
			OP_SHR:    lo = a >> sh;
			// Sign fill
			OP_SHRA:   lo = $signed(a) >>> sh;
			OP_SHL:    lo = a << sh;
			OP_ROR:    lo = rot_r[`ALU_WIDTH-1:0];
			OP_ROL:    lo = rot_l[2*`ALU_WIDTH-1:`ALU_WIDTH];
			// MUL, DIV and unused codes
			default:   lo = '0;
		endcase
	end

	// Upper half unused by these ops
	assign res = {{`ALU_WIDTH{1'b0}}, lo};

endmodule

//--- source/booth_multiplier.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module booth_multiplier (
	input  logic clk,
	input  logic rst,
	iter_if.unit port
);

	// Multiplicand held for the whole run
	logic [`ALU_WIDTH-1:0] mcand;
	// Two guard bits so that 2a and its sum fit
	logic [`ALU_WIDTH+1:0] mcand_x;
	logic [`ALU_WIDTH+1:0] pp;
	logic [`ALU_WIDTH+1:0] sum;
	// Upper partial product
	logic [`ALU_WIDTH+1:0] acc;
	// Multiplier bits, refilled from the top with product bits
	logic [`ALU_WIDTH-1:0] mplr;
	// Bit shifted out last step
	logic                  q_m1;
	logic [2:0]            triple;

	assign mcand_x = {{2{mcand[`ALU_WIDTH-1]}}, mcand};
	assign triple  = {mplr[1:0], q_m1};

	// Bit-pair recoding
	always_comb begin
		case (triple)
			3'b001, 3'b010: pp = mcand_x;
			3'b011:         pp = mcand_x << 1;
			3'b100:         pp = -(mcand_x << 1);
			3'b101, 3'b110: pp = -mcand_x;
			// 000 and 111 add nothing
			default:        pp = '0;
		endcase
	end

	assign sum = acc + pp;

	always_ff @(posedge clk) begin
		if (port.load)
			mcand <= port.a;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc  <= '0;
			mplr <= '0;
			q_m1 <= 1'b0;
		end else if (port.load) begin
			acc  <= '0;
			mplr <= port.b;
			q_m1 <= 1'b0;
		end else if (port.step) begin
			// Arithmetic shift by two of {sum, mplr}
			acc  <= {{2{sum[`ALU_WIDTH+1]}}, sum[`ALU_WIDTH+1:2]};
			mplr <= {sum[1:0], mplr[`ALU_WIDTH-1:2]};
			q_m1 <= mplr[1];
		end
	end

	// Product after 16 steps
	assign port.hi = acc[`ALU_WIDTH-1:0];
	assign port.lo = mplr;

endmodule

//--- source/nonrestoring_divider.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module nonrestoring_divider (
	input  logic clk,
	input  logic rst,
	iter_if.unit port
);

	// Operand magnitudes at load time
	logic [`ALU_WIDTH-1:0] a_mag;
	logic [`ALU_WIDTH-1:0] b_mag;
	logic [`ALU_WIDTH-1:0] d_mag;
	// Signed partial remainder, one bit wider than the divisor
	logic [`ALU_WIDTH:0]   r;
	logic [`ALU_WIDTH:0]   r_shift;
	logic [`ALU_WIDTH:0]   r_next;
	logic [`ALU_WIDTH:0]   r_fix;
	// Dividend bits in, quotient bits out
	logic [`ALU_WIDTH-1:0] q_reg;
	logic [`ALU_WIDTH-1:0] q_next;
	logic [`ALU_WIDTH-1:0] rem_mag;
	logic                  sa;
	logic                  sb;
	logic                  dz;
	logic [`ALU_WIDTH-1:0] hi_q;
	logic [`ALU_WIDTH-1:0] lo_q;

	assign a_mag = port.a[`ALU_WIDTH-1] ? -port.a : port.a;
	assign b_mag = port.b[`ALU_WIDTH-1] ? -port.b : port.b;

	// Subtract after a positive remainder, add after a negative one
	assign r_shift = {r[`ALU_WIDTH-1:0], q_reg[`ALU_WIDTH-1]};
	assign r_next  = r[`ALU_WIDTH] ? r_shift + {1'b0, d_mag} : r_shift - {1'b0, d_mag};
	assign q_next  = {q_reg[`ALU_WIDTH-2:0], ~r_next[`ALU_WIDTH]};

	// Restore a negative final remainder
	assign r_fix   = r[`ALU_WIDTH] ? r + {1'b0, d_mag} : r;
	assign rem_mag = r_fix[`ALU_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (port.load) begin
			r     <= '0;
			q_reg <= a_mag;
			d_mag <= b_mag;
			sa    <= port.a[`ALU_WIDTH-1];
			sb    <= port.b[`ALU_WIDTH-1];
			dz    <= (port.b == '0);
		end else if (port.step) begin
			r     <= r_next;
			q_reg <= q_next;
		end
	end

	// Output stage trails the iteration by one step
	// Its capture on the step after the last one is the sign fix-up
	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (port.step) begin
			// Remainder follows the dividend sign
			hi_q <= sa ? -rem_mag : rem_mag;
			// Quotient truncates toward zero
			lo_q <= dz ? '1 : ((sa ^ sb) ? -q_reg : q_reg);
		end
	end

	assign port.hi = hi_q;
	assign port.lo = lo_q;

endmodule

//--- source/alu_top.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_top
	import alu_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req,
	input  alu_op_e                 op,
	input  logic [`ALU_WIDTH-1:0]   y,
	input  logic [`ALU_WIDTH-1:0]   bus_in,
	output logic                    ack,
	output logic [2*`ALU_WIDTH-1:0] c
);

	// Controller to counter
	logic                    cnt_start;
	logic                    cnt_last;
	logic [5:0]              cnt_steps;
	// Latched operands for the single-cycle path
	logic [`ALU_WIDTH-1:0]   a_q;
	logic [`ALU_WIDTH-1:0]   b_q;
	alu_op_e                 op_q;
	logic [2*`ALU_WIDTH-1:0] simple_res;

	// Iterative unit links
	iter_if mul_if ();
	iter_if div_if ();

	alu_ctrl i_ctrl (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.op         (op),
		.y          (y),
		.bus_in     (bus_in),
		.ack        (ack),
		.c          (c),
		.cnt_start  (cnt_start),
		.cnt_steps  (cnt_steps),
		.cnt_last   (cnt_last),
		.mul        (mul_if.ctrl),
		.div        (div_if.ctrl),
		.a_q        (a_q),
		.b_q        (b_q),
		.op_q       (op_q),
		.simple_res (simple_res)
	);

	// Iteration timer for MUL and DIV
	step_counter i_cnt (
		.clk   (clk),
		.rst   (rst),
		.start (cnt_start),
		.steps (cnt_steps),
		.busy  (),
		.last  (cnt_last)
	);

	single_cycle_unit i_scu (
		.a   (a_q),
		.b   (b_q),
		.op  (op_q),
		.res (simple_res)
	);

	booth_multiplier i_mul (
		.clk  (clk),
		.rst  (rst),
		.port (mul_if.unit)
	);

	nonrestoring_divider i_div (
		.clk  (clk),
		.rst  (rst),
		.port (div_if.unit)
	);

endmodule

//--- tests/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Rotate right, bits leaving the bottom re-enter at the top
function automatic logic [`ALU_WIDTH-1:0] rotate_right(logic [`ALU_WIDTH-1:0] x, int s);
	if (s == 0)
		return x;
	return (x >> s) | (x << (`ALU_WIDTH - s));
endfunction

// Rotate left, mirror of the above
function automatic logic [`ALU_WIDTH-1:0] rotate_left(logic [`ALU_WIDTH-1:0] x, int s);
	if (s == 0)
		return x;
	return (x << s) | (x >> (`ALU_WIDTH - s));
endfunction

// Right shift with the sign bit copied into the vacated bits
function automatic logic [`ALU_WIDTH-1:0] arith_shift_right(logic [`ALU_WIDTH-1:0] x, int s);
	logic [`ALU_WIDTH-1:0] fill;
	fill = x[`ALU_WIDTH-1] ? ~({`ALU_WIDTH{1'b1}} >> s) : '0;
	return (x >> s) | fill;
endfunction

// Full signed 64-bit product
function automatic logic [2*`ALU_WIDTH-1:0] signed_product(logic [`ALU_WIDTH-1:0] a,
		logic [`ALU_WIDTH-1:0] b);
	longint p;
	p = longint'($signed(a)) * longint'($signed(b));
	return p;
endfunction

// Remainder high, quotient low; divide by zero gives all ones and the dividend
function automatic logic [2*`ALU_WIDTH-1:0] signed_divide(logic [`ALU_WIDTH-1:0] a,
		logic [`ALU_WIDTH-1:0] b);
	longint n;
	longint d;
	longint q;
	longint r;
	if (b == '0)
		return {a, {`ALU_WIDTH{1'b1}}};
	n = longint'($signed(a));
	d = longint'($signed(b));
	// Truncating quotient, remainder keeps the dividend sign
	q = n / d;
	r = n % d;
	return {r[`ALU_WIDTH-1:0], q[`ALU_WIDTH-1:0]};
endfunction

// Expected c for one operation
function automatic logic [2*`ALU_WIDTH-1:0] expected_result(alu_op_e opc,
		logic [`ALU_WIDTH-1:0] a, logic [`ALU_WIDTH-1:0] b);
	int s;
	logic [`ALU_WIDTH-1:0] lo;
	s = int'(b[4:0]);
	case (opc)
		OP_AND:    lo = a & b;
		OP_OR:     lo = a | b;
		OP_NEGATE: lo = ~a + 32'd1;
		OP_NOT:    lo = ~a;
		OP_ADD:    lo = a + b;
		OP_SUB:    lo = a + ~b + 32'd1;
		OP_MUL:    return signed_product(a, b);
		OP_DIV:    return signed_divide(a, b);
		OP_SHR:    lo = a >> s;
		OP_SHRA:   lo = arith_shift_right(a, s);
		OP_SHL:    lo = a << s;
		OP_ROR:    lo = rotate_right(a, s);
		OP_ROL:    lo = rotate_left(a, s);
		// Unused codes
		default:   lo = '0;
	endcase
	return {{`ALU_WIDTH{1'b0}}, lo};
endfunction

`endif

//--- tests/tb_alu_top.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu_top
	import alu_pkg::*;
();

	// Run limit from the transaction budget
	localparam int MAX_TRANS        = 400;
	localparam int CYCLES_PER_TRANS = 40;
	localparam int TIMEOUT_CYCLES   = MAX_TRANS * CYCLES_PER_TRANS + 100;
	localparam int ACK_WAIT_LIMIT   = 64;

	logic                    clk;
	logic                    rst;
	logic                    req;
	alu_op_e                 op;
	logic [`ALU_WIDTH-1:0]   y;
	logic [`ALU_WIDTH-1:0]   bus_in;
	logic                    ack;
	logic [2*`ALU_WIDTH-1:0] c;

	integer seed;
	int     errors;
	int     checks;
	int     cycles;

	`include "alu_model.svh"

	alu_top i_dut (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.op     (op),
		.y      (y),
		.bus_in (bus_in),
		.ack    (ack),
		.c      (c)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Stops a stalled handshake
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycles);
		$display("Errors found");
		$finish;
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("Handshake error at %0t ns: %s", $time, what);
	endtask

	// Fixed by the controller timing
	function automatic int expected_latency(alu_op_e opc);
		if (opc == OP_MUL)
			return 18;
		if (opc == OP_DIV)
			return 35;
		return 2;
	endfunction

	// Edge values mixed with plain random words
	function automatic logic [`ALU_WIDTH-1:0] pick_operand();
		int kind;
		kind = int'($unsigned($random(seed)) % 8);
		case (kind)
			0:       return '0;
			1:       return '1;
			2:       return 32'h8000_0000;
			3:       return 32'h7fff_ffff;
			4:       return 32'd1;
			default: return $random(seed);
		endcase
	endfunction

	// Any one-cycle opcode, skipping MUL and DIV
	function automatic alu_op_e pick_single_op();
		int idx;
		idx = int'($unsigned($random(seed)) % 11);
		if (idx >= 6)
			idx = idx + 2;
		return alu_op_e'(idx[3:0]);
	endfunction

	// One four-phase transaction, entered and left 1 ns after an edge
	task automatic run_op(input alu_op_e opc, input logic [`ALU_WIDTH-1:0] a,
			input logic [`ALU_WIDTH-1:0] b, output logic [2*`ALU_WIDTH-1:0] result);
		int lat;
		int hold;
		if (ack)
			report("ack already high before req rose");
		op     = opc;
		y      = a;
		bus_in = b;
		req    = 1'b1;
		// Edge that samples req is cycle 0
		@(posedge clk);
		#1;
		lat = 0;
		while (!ack && lat < ACK_WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			lat++;
		end
		if (!ack)
			report("ack never rose after req");
		check_value(64'(lat), 64'(expected_latency(opc)), "ack latency");
		result = c;
		// Back-pressure, req stays high a while
		hold = int'($unsigned($random(seed)) % 4);
		repeat (hold) begin
			@(posedge clk);
			#1;
			if (!ack)
				report("ack dropped while req was still high");
			if (c !== result)
				report("c changed while ack was high");
		end
		req    = 1'b0;
		y      = $random(seed);
		bus_in = $random(seed);
		@(posedge clk);
		#1;
		if (ack)
			report("ack stayed high after req dropped");
		if (c !== result)
			report("c changed after ack fell");
	endtask

	task automatic run_and_check(input alu_op_e opc, input logic [`ALU_WIDTH-1:0] a,
			input logic [`ALU_WIDTH-1:0] b);
		logic [2*`ALU_WIDTH-1:0] result;
		run_op(opc, a, b, result);
		check_value(result, expected_result(opc, a, b),
			$sformatf("op %0d a=%h b=%h", opc, a, b));
	endtask

	initial begin
		int i;
		seed   = 96577;
		errors = 0;
		checks = 0;
		rst    = 1'b1;
		req    = 1'b0;
		op     = OP_AND;
		y      = '0;
		bus_in = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// Quiet outputs before any request
		repeat (2) begin
			@(posedge clk);
			#1;
			if (ack)
				report("ack high with no request after reset");
		end
		check_value(c, '0, "c after reset");

		for (i = 0; i < 150; i++)
			run_and_check(pick_single_op(), pick_operand(), pick_operand());

		for (i = 0; i < 80; i++)
			run_and_check(OP_MUL, pick_operand(), pick_operand());

		for (i = 0; i < 80; i++)
			run_and_check(OP_DIV, pick_operand(), pick_operand());

		// Divide by zero, several dividends
		run_and_check(OP_DIV, 32'd0, '0);
		run_and_check(OP_DIV, 32'd7, '0);
		run_and_check(OP_DIV, -32'sd7, '0);
		run_and_check(OP_DIV, 32'h8000_0000, '0);
		run_and_check(OP_DIV, $random(seed), '0);

		// Codes 13 to 15
		for (i = 13; i < 16; i++)
			run_and_check(alu_op_e'(i[3:0]), pick_operand(), pick_operand());

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- sim.f
+incdir+source
+incdir+tests
source/alu_pkg.sv
source/iter_if.sv
source/alu_ctrl.sv
source/step_counter.sv
source/single_cycle_unit.sv
source/booth_multiplier.sv
source/nonrestoring_divider.sv
source/alu_top.sv
tests/tb_alu_top.sv

//--- Makefile
TOP = tb_alu_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
